//--- include/smu_ctl_config.svh
/*
  board constants for the smu control fpga
  frame length, nibble width, peripheral count, synchronizer depth
  and the power-on / soft-reset default of every control register
*/
`ifndef SMU_CTL_CONFIG_SVH
`define SMU_CTL_CONFIG_SVH

// spi frame is address byte then set/clear byte
`define SMU_FRAME_BITS 16

// every control register is one nibble wide
`define SMU_NIB_W 4

// adc03, dac, flash, adc02
`define SMU_PERIPH_N 4

// flops between the mcu pins and the clk domain
`define SMU_SYNC_STAGES 2

//////////////////////////////////////////////////////////////////////
// register defaults

`define SMU_DEF_LED         4'b0000
`define SMU_DEF_MUX         4'b0000
`define SMU_DEF_DAC         4'b0000
`define SMU_DEF_RAILS       4'b0000
// dg444 switches, active low, so all off
`define SMU_DEF_DAC_REF_MUX 4'b1111
`define SMU_DEF_ADC         4'b0000
// clamp switches are active low too
`define SMU_DEF_CLAMP1      4'b1111
`define SMU_DEF_CLAMP2      4'b1111
// rails output enable is active low, bit 0 high keeps rails off
`define SMU_DEF_RAILS_OE    4'b0001

`endif

//--- src/smu_ctl_pkg.sv
/*
  shared types for the smu control fpga
  register address enum, receiver states, nibble type
  and the set / clear / toggle update function
*/
`default_nettype none

`include "smu_ctl_config.svh"

package smu_ctl_pkg;

  // one control register
  typedef logic [`SMU_NIB_W-1:0] nibble_t;

  // high byte of a frame, only these addresses do anything
  typedef enum logic [7:0] {
    ADDR_LED         = 8'd7,
    ADDR_MUX         = 8'd8,
    ADDR_DAC         = 8'd9,
    ADDR_RAILS       = 8'd10,
    ADDR_SOFT_RESET  = 8'd11,
    ADDR_DAC_REF_MUX = 8'd12,
    ADDR_ADC         = 8'd14,
    ADDR_CLAMP1      = 8'd15,
    ADDR_CLAMP2      = 8'd16,
    ADDR_RAILS_OE    = 8'd24
  } reg_addr_t;

  // spi receiver fsm
  typedef enum logic [1:0] {
    RX_IDLE,
    RX_SHIFT,
    RX_IGNORE
  } rx_state_t;

  // low nibble sets, high nibble clears, both means toggle
  function automatic nibble_t nibble_update(input nibble_t old_val,
                                            input logic [2*`SMU_NIB_W-1:0] val);
    nibble_t set_bits;
    nibble_t clr_bits;
    nibble_t overlap;
    set_bits = val[`SMU_NIB_W-1:0];
    clr_bits = val[2*`SMU_NIB_W-1:`SMU_NIB_W];
    overlap  = set_bits & clr_bits;
    // any overlap turns the whole write into a toggle of those bits
    if (overlap != '0)
      return old_val ^ overlap;
    return (old_val | set_bits) & ~clr_bits;
  endfunction

endpackage

`default_nettype wire

//--- src/spi_frame_rx.sv
/*
  spi frame receiver in the clk domain
  pin synchronizer, sclk / cs_n edge detect, 16 bit shift register
  and a one-cycle frame_valid for good register writes
*/
`default_nettype none

`include "smu_ctl_config.svh"

module spi_frame_rx (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  sclk,
  input  logic                  cs_n,
  input  logic                  special_n,
  input  logic                  mosi,
  output logic                  frame_valid,
  output smu_ctl_pkg::reg_addr_t frame_addr,
  output logic [7:0]            frame_val
);

  import smu_ctl_pkg::*;

  // room for one bit past a full frame, saturates above that
  localparam int CNT_W = $clog2(`SMU_FRAME_BITS + 2);

  // pin vector order is {mosi, special_n, cs_n, sclk}
  localparam logic [3:0] PIN_IDLE = 4'b0110;

  logic [3:0]                 pins;
  logic [3:0]                 sync_q [`SMU_SYNC_STAGES];
  logic                       sclk_s;
  logic                       cs_n_s;
  logic                       special_n_s;
  logic                       mosi_s;
  logic                       sclk_d;
  logic                       cs_n_d;
  logic                       sclk_rise;
  logic                       cs_rise;
  logic                       cs_fall;
  logic                       shift_en;
  rx_state_t                  state;
  logic [CNT_W-1:0]           bit_cnt;
  logic [`SMU_FRAME_BITS-1:0] shift_q;

  //////////////////////////////////////////////////////////////////////
  // synchronizer and edge detect

  assign pins = {mosi, special_n, cs_n, sclk};

  // all four pins go through the same depth so they stay aligned
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < `SMU_SYNC_STAGES; i++)
        sync_q[i] <= PIN_IDLE;
      sclk_d <= 1'b0;
      cs_n_d <= 1'b1;
    end
    else
    begin
      sync_q[0] <= pins;
      for (int i = 1; i < `SMU_SYNC_STAGES; i++)
        sync_q[i] <= sync_q[i-1];
      sclk_d <= sclk_s;
      cs_n_d <= cs_n_s;
    end
  end

  assign {mosi_s, special_n_s, cs_n_s, sclk_s} = sync_q[`SMU_SYNC_STAGES-1];

  assign sclk_rise = sclk_s & ~sclk_d;
  assign cs_rise   = cs_n_s & ~cs_n_d;
  assign cs_fall   = ~cs_n_s & cs_n_d;

  // mosi taken on the synchronized sclk rising edge, msb first
  assign shift_en = (state == RX_SHIFT) && sclk_rise && !cs_rise && !special_n_s;

  //////////////////////////////////////////////////////////////////////
  // receiver fsm

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state       <= RX_IDLE;
      bit_cnt     <= '0;
      frame_valid <= 1'b0;
    end
    else
    begin
      frame_valid <= 1'b0;
      case (state)
        RX_IDLE:
          if (cs_fall)
          begin
            bit_cnt <= '0;
            // peripheral traffic, nothing for us
            state   <= special_n_s ? RX_IGNORE : RX_SHIFT;
          end
        RX_SHIFT:
          // cs_n release wins over a late special_n edge
          if (cs_rise)
          begin
            frame_valid <= (bit_cnt == CNT_W'(`SMU_FRAME_BITS));
            state       <= RX_IDLE;
          end
          else if (special_n_s)
            state <= RX_IGNORE;
          else if (shift_en && bit_cnt != '1)
            bit_cnt <= bit_cnt + 1'b1;
        RX_IGNORE:
          if (cs_rise)
            state <= RX_IDLE;
        default:
          state <= RX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (shift_en)
      shift_q <= {shift_q[`SMU_FRAME_BITS-2:0], mosi_s};
  end

  // shift register holds still between frames
  assign frame_addr = reg_addr_t'(shift_q[`SMU_FRAME_BITS-1 -: 8]);
  assign frame_val  = shift_q[7:0];

endmodule

`default_nettype wire

//--- src/control_reg_bank.sv
/*
  control register bank
  address decode, nibble set / clear / toggle writes
  soft reset to board defaults
*/
`default_nettype none

`include "smu_ctl_config.svh"

module control_reg_bank (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   frame_valid,
  input  smu_ctl_pkg::reg_addr_t frame_addr,
  input  logic [7:0]             frame_val,
  output smu_ctl_pkg::nibble_t   reg_led,
  output smu_ctl_pkg::nibble_t   reg_mux,
  output smu_ctl_pkg::nibble_t   reg_dac,
  output smu_ctl_pkg::nibble_t   reg_rails,
  output smu_ctl_pkg::nibble_t   reg_dac_ref_mux,
  output smu_ctl_pkg::nibble_t   reg_adc,
  output smu_ctl_pkg::nibble_t   reg_clamp1,
  output smu_ctl_pkg::nibble_t   reg_clamp2,
  output smu_ctl_pkg::nibble_t   reg_rails_oe
);

  import smu_ctl_pkg::*;

  logic soft_reset;

  // address 11 with any value
  assign soft_reset = frame_valid && (frame_addr == ADDR_SOFT_RESET);

  //////////////////////////////////////////////////////////////////////
  // register file

  always_ff @(posedge clk)
  begin
    if (reset || soft_reset)
    begin
      // both resets load the board defaults
      reg_led         <= `SMU_DEF_LED;
      reg_mux         <= `SMU_DEF_MUX;
      reg_dac         <= `SMU_DEF_DAC;
      reg_rails       <= `SMU_DEF_RAILS;
      // active low analog switches start open
      reg_dac_ref_mux <= `SMU_DEF_DAC_REF_MUX;
      reg_adc         <= `SMU_DEF_ADC;
      reg_clamp1      <= `SMU_DEF_CLAMP1;
      reg_clamp2      <= `SMU_DEF_CLAMP2;
      // rails stay disabled until the mcu enables them
      reg_rails_oe    <= `SMU_DEF_RAILS_OE;
    end
    else if (frame_valid)
    begin
      case (frame_addr)
        // leds
        ADDR_LED:
          reg_led <= nibble_update(reg_led, frame_val);
        // peripheral chip select mask
        ADDR_MUX:
          reg_mux <= nibble_update(reg_mux, frame_val);
        // dac ldac, uni/bip, rst
        ADDR_DAC:
          reg_dac <= nibble_update(reg_dac, frame_val);
        // low power rail enables
        ADDR_RAILS:
          reg_rails <= nibble_update(reg_rails, frame_val);
        ADDR_DAC_REF_MUX:
          reg_dac_ref_mux <= nibble_update(reg_dac_ref_mux, frame_val);
        // adc02 mode pins and reset
        ADDR_ADC:
          reg_adc <= nibble_update(reg_adc, frame_val);
        ADDR_CLAMP1:
          reg_clamp1 <= nibble_update(reg_clamp1, frame_val);
        ADDR_CLAMP2:
          reg_clamp2 <= nibble_update(reg_clamp2, frame_val);
        ADDR_RAILS_OE:
          reg_rails_oe <= nibble_update(reg_rails_oe, frame_val);
        // unknown address, drop the write
        default:
          ;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- src/spi_route.sv
/*
  peripheral chip-select fan-out and miso select
  purely combinational, driven straight from the pins and reg_mux
*/
`default_nettype none

`include "smu_ctl_config.svh"

module spi_route (
  input  logic                     cs_n,
  input  logic                     special_n,
  input  smu_ctl_pkg::nibble_t     reg_mux,
  input  logic [`SMU_PERIPH_N-1:0] periph_miso,
  output logic [`SMU_PERIPH_N-1:0] periph_cs_n,
  output logic                     miso
);

  always_comb
  begin
    if (special_n)
    begin
      // peripheral access, cs_n goes only where reg_mux points
      periph_cs_n = {`SMU_PERIPH_N{cs_n}} | ~reg_mux;
      // selected peripherals share miso
      miso        = |(reg_mux & periph_miso);
    end
    else
    begin
      // fpga register write
      // keep every peripheral deselected so none sees the frame
      periph_cs_n = '1;
      // no readback from the fpga itself
      miso        = 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- src/smu_ctl_top.sv
/*
  smu control fpga top level
  spi receiver, control register bank, chip-select router
  and sclk / mosi pass-through to the peripherals
*/
`default_nettype none

`include "smu_ctl_config.svh"

module smu_ctl_top (
  input  logic                     clk,
  input  logic                     reset,

  // mcu spi
  input  logic                     sclk,
  input  logic                     cs_n,
  input  logic                     special_n,
  input  logic                     mosi,
  output logic                     miso,

  // peripheral spi, bit 0 adc03, 1 dac, 2 flash, 3 adc02
  input  logic [`SMU_PERIPH_N-1:0] periph_miso,
  output logic [`SMU_PERIPH_N-1:0] periph_cs_n,
  output logic                     periph_sclk,
  output logic                     periph_mosi,

  // board control nibbles
  output smu_ctl_pkg::nibble_t     led,
  output smu_ctl_pkg::nibble_t     dac_ctl,
  output smu_ctl_pkg::nibble_t     rails,
  output smu_ctl_pkg::nibble_t     dac_ref_mux,
  output smu_ctl_pkg::nibble_t     adc_ctl,
  output smu_ctl_pkg::nibble_t     clamp1,
  output smu_ctl_pkg::nibble_t     clamp2,
  output smu_ctl_pkg::nibble_t     rails_oe
);

  import smu_ctl_pkg::*;

  logic       frame_valid;
  reg_addr_t  frame_addr;
  logic [7:0] frame_val;
  nibble_t    reg_mux;

  //////////////////////////////////////////////////////////////////////
  // spi pass-through

  // clock and data are shared by every peripheral, only cs is routed
  assign periph_sclk = sclk;
  assign periph_mosi = mosi;

  spi_route u_route (
    .cs_n        (cs_n),
    .special_n   (special_n),
    .reg_mux     (reg_mux),
    .periph_miso (periph_miso),
    .periph_cs_n (periph_cs_n),
    .miso        (miso)
  );

  //////////////////////////////////////////////////////////////////////
  // register path

  spi_frame_rx u_rx (
    .clk         (clk),
    .reset       (reset),
    .sclk        (sclk),
    .cs_n        (cs_n),
    .special_n   (special_n),
    .mosi        (mosi),
    .frame_valid (frame_valid),
    .frame_addr  (frame_addr),
    .frame_val   (frame_val)
  );

  // reg_mux stays internal, it only steers the router
  control_reg_bank u_bank (
    .clk             (clk),
    .reset           (reset),
    .frame_valid     (frame_valid),
    .frame_addr      (frame_addr),
    .frame_val       (frame_val),
    .reg_led         (led),
    .reg_mux         (reg_mux),
    .reg_dac         (dac_ctl),
    .reg_rails       (rails),
    .reg_dac_ref_mux (dac_ref_mux),
    .reg_adc         (adc_ctl),
    .reg_clamp1      (clamp1),
    .reg_clamp2      (clamp2),
    .reg_rails_oe    (rails_oe)
  );

endmodule

`default_nettype wire

//--- bench/smu_ctl_chk.sv
/*
  concurrent checks bound into the smu control top level
  chip-select idle rules and the rails_oe reset value
*/
`default_nettype none

`include "smu_ctl_config.svh"

module smu_ctl_chk (
  input logic                     clk,
  input logic                     reset,
  input logic                     cs_n,
  input logic                     special_n,
  input logic [`SMU_PERIPH_N-1:0] periph_cs_n,
  input logic [`SMU_NIB_W-1:0]    rails_oe
);

  timeunit 1ns;
  timeprecision 100ps;

  // bumped by every failing assertion, read by the testbench
  int assert_fails = 0;

  //////////////////////////////////////////////////////////////////////
  // chip-select rules

  // fpga register writes never reach a peripheral
  a_special_deselect : assert property (@(posedge clk) disable iff (reset)
    !special_n |-> periph_cs_n == '1)
  else
  begin
    assert_fails++;
    $error("a peripheral chip select went low while special_n was low");
  end

  // no peripheral selected without the mcu chip select
  a_idle_deselect : assert property (@(posedge clk) disable iff (reset)
    cs_n |-> periph_cs_n == '1)
  else
  begin
    assert_fails++;
    $error("a peripheral chip select went low while cs_n was high");
  end

  // rails stay disabled coming out of reset
  a_rails_oe_reset : assert property (@(posedge clk)
    $fell(reset) |-> rails_oe == `SMU_DEF_RAILS_OE)
  else
  begin
    assert_fails++;
    $error("rails_oe did not hold its default in the cycle after reset");
  end

endmodule

bind smu_ctl_top smu_ctl_chk chk (
  .clk         (clk),
  .reset       (reset),
  .cs_n        (cs_n),
  .special_n   (special_n),
  .periph_cs_n (periph_cs_n),
  .rails_oe    (rails_oe)
);

`default_nettype wire

//--- bench/smu_ctl_tb.sv
/*
  testbench for the smu control fpga
  spi frame driver, xorshift stimulus, register model, routing probe
  error counting and watchdog
*/
`default_nettype none

`include "smu_ctl_config.svh"

module smu_ctl_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import smu_ctl_pkg::*;

  localparam int CLK_PERIOD = 10;
  localparam int SCLK_HALF  = 5;
  localparam int N_REGS     = 9;
  // upper bound on frames sent over the whole run
  localparam int N_FRAMES   = 70;
  // longest frame plus cs setup, settle time and the routing probe
  localparam int FRAME_CYCLES = (`SMU_FRAME_BITS + 1) * 2 * SCLK_HALF + 40;
  localparam int TIMEOUT_NS   = (N_FRAMES * FRAME_CYCLES + 500) * CLK_PERIOD;

  // led, mux, dac, rails, dac_ref_mux, adc, clamp1, clamp2, rails_oe
  localparam logic [7:0] REG_ADDR [N_REGS] = '{8'd7, 8'd8, 8'd9, 8'd10, 8'd12,
                                               8'd14, 8'd15, 8'd16, 8'd24};
  // addresses the bank must ignore
  localparam logic [7:0] BAD_ADDR [3] = '{8'd0, 8'd13, 8'd200};

  logic       clk;
  logic       reset;
  logic       sclk;
  logic       cs_n;
  logic       special_n;
  logic       mosi;
  logic [3:0] periph_miso;
  logic       miso;
  logic [3:0] periph_cs_n;
  logic       periph_sclk;
  logic       periph_mosi;
  nibble_t    led;
  nibble_t    dac_ctl;
  nibble_t    rails;
  nibble_t    dac_ref_mux;
  nibble_t    adc_ctl;
  nibble_t    clamp1;
  nibble_t    clamp2;
  nibble_t    rails_oe;

  // expected register contents, same order as REG_ADDR
  nibble_t     exp_reg [N_REGS];
  int          errors    = 0;
  logic [31:0] rng_state = 32'd91;

  smu_ctl_top dut (.*);

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // helpers

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic nibble_t default_of(input int idx);
    case (idx)
      4:       return `SMU_DEF_DAC_REF_MUX;
      6:       return `SMU_DEF_CLAMP1;
      7:       return `SMU_DEF_CLAMP2;
      8:       return `SMU_DEF_RAILS_OE;
      default: return 4'b0000;
    endcase
  endfunction

  // bit by bit, any bit named in both nibbles turns the frame into a toggle
  function automatic nibble_t apply_set_clear(input nibble_t old_val,
                                              input logic [7:0] val);
    nibble_t result;
    logic    toggle;
    result = old_val;
    toggle = 1'b0;
    for (int b = 0; b < 4; b++)
    begin
      if (val[b] && val[b+4])
        toggle = 1'b1;
    end
    for (int b = 0; b < 4; b++)
    begin
      if (toggle)
      begin
        if (val[b] && val[b+4])
          result[b] = ~old_val[b];
      end
      else if (val[b])
        result[b] = 1'b1;
      else if (val[b+4])
        result[b] = 1'b0;
    end
    return result;
  endfunction

  // mux has no pin of its own, probe_route covers it
  function automatic nibble_t actual_of(input int idx);
    case (idx)
      0:       return led;
      2:       return dac_ctl;
      3:       return rails;
      4:       return dac_ref_mux;
      5:       return adc_ctl;
      6:       return clamp1;
      7:       return clamp2;
      default: return rails_oe;
    endcase
  endfunction

  task automatic compare_value(input string name, input logic [3:0] expected,
                               input logic [3:0] actual);
    assert (actual === expected)
    else
    begin
      $display("ERROR %s expected %h actual %h", name, expected, actual);
      errors++;
    end
  endtask

  // address 11 reloads defaults, unknown addresses do nothing
  task automatic model_write(input logic [7:0] addr, input logic [7:0] val);
    for (int i = 0; i < N_REGS; i++)
    begin
      if (addr == 8'd11)
        exp_reg[i] = default_of(i);
      else if (REG_ADDR[i] == addr)
        exp_reg[i] = apply_set_clear(exp_reg[i], val);
    end
  endtask

  // spi mode 0, msb first, special_n rises before bit cut_at when cut_at >= 0
  task automatic send_frame(input int nbits, input logic [16:0] bits, input int cut_at);
    @(negedge clk);
    special_n = 1'b0;
    cs_n      = 1'b0;
    repeat (SCLK_HALF) @(negedge clk);
    for (int i = 0; i < nbits; i++)
    begin
      if (i == cut_at)
        special_n = 1'b1;
      mosi = bits[nbits-1-i];
      repeat (SCLK_HALF) @(negedge clk);
      sclk = 1'b1;
      repeat (SCLK_HALF) @(negedge clk);
      sclk = 1'b0;
    end
    repeat (SCLK_HALF) @(negedge clk);
    cs_n      = 1'b1;
    special_n = 1'b1;
    mosi      = 1'b0;
    // update lands within 5 cycles of cs_n
    repeat (8) @(negedge clk);
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [7:0] val);
    send_frame(16, {1'b0, addr, val}, -1);
    model_write(addr, val);
  endtask

  // peripheral access with random miso, then a register-write window
  task automatic probe_route(input string name);
    logic [31:0] r;
    logic [3:0]  pm;
    logic        exp_miso;
    r  = next_random();
    pm = r[3:0];
    exp_miso = 1'b0;
    for (int b = 0; b < 4; b++)
    begin
      if (exp_reg[1][b] && pm[b])
        exp_miso = 1'b1;
    end
    periph_miso = pm;
    cs_n        = 1'b0;
    sclk        = 1'b1;
    mosi        = pm[0];
    @(negedge clk);
    compare_value({name, " cs_n"}, ~exp_reg[1], periph_cs_n);
    compare_value({name, " miso"}, {3'b000, exp_miso}, {3'b000, miso});
    compare_value({name, " sclk high"}, 4'h1, {3'b000, periph_sclk});
    compare_value({name, " mosi"}, {3'b000, pm[0]}, {3'b000, periph_mosi});
    special_n = 1'b0;
    mosi      = ~pm[0];
    @(negedge clk);
    compare_value({name, " cs_n special"}, 4'hf, periph_cs_n);
    compare_value({name, " miso special"}, 4'h0, {3'b000, miso});
    compare_value({name, " mosi special"}, {3'b000, ~pm[0]}, {3'b000, periph_mosi});
    cs_n      = 1'b1;
    special_n = 1'b1;
    sclk      = 1'b0;
    mosi      = 1'b0;
    @(negedge clk);
    compare_value({name, " cs_n idle"}, 4'hf, periph_cs_n);
    compare_value({name, " sclk low"}, 4'h0, {3'b000, periph_sclk});
    // receiver has to see cs_n back high
    repeat (4) @(negedge clk);
  endtask

  task automatic compare_all(input string name);
    for (int i = 0; i < N_REGS; i++)
    begin
      if (i != 1)
        compare_value($sformatf("%s reg %0d", name, REG_ADDR[i]), exp_reg[i], actual_of(i));
    end
    probe_route(name);
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus

  initial
  begin
    logic [31:0] r;
    logic [15:0] w;
    int          idx;
    reset       = 1'b1;
    sclk        = 1'b0;
    cs_n        = 1'b1;
    special_n   = 1'b1;
    mosi        = 1'b0;
    periph_miso = 4'h0;
    for (int i = 0; i < N_REGS; i++)
      exp_reg[i] = default_of(i);
    repeat (2) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    compare_all("reset");

    // set / clear / toggle on every kept register
    for (int round = 0; round < 4; round++)
    begin
      for (int i = 0; i < N_REGS; i++)
      begin
        r = next_random();
        write_reg(REG_ADDR[i], r[7:0]);
        compare_all($sformatf("write %0d", REG_ADDR[i]));
      end
    end

    // short, long, cut and misaddressed frames
    for (int round = 0; round < 3; round++)
    begin
      r   = next_random();
      idx = int'(r[15:8]) % N_REGS;
      w   = {REG_ADDR[idx], r[7:0]};
      send_frame(15, {2'b00, w[15:1]}, -1);
      compare_all("15 bit frame");
      // last 16 bits form a real write, only the count rejects it
      send_frame(17, {r[16], w}, -1);
      compare_all("17 bit frame");
      send_frame(16, {1'b0, w}, 8);
      compare_all("special_n cut");
      write_reg(BAD_ADDR[round], r[7:0]);
      compare_all("unknown address");
    end

    // soft reset after a burst of writes
    for (int n = 0; n < 10; n++)
    begin
      r   = next_random();
      idx = int'(r[15:8]) % N_REGS;
      write_reg(REG_ADDR[idx], r[7:0]);
    end
    compare_all("before soft reset");
    r = next_random();
    write_reg(8'd11, r[7:0]);
    compare_all("soft reset");

    // routing with fresh mux masks
    for (int n = 0; n < 4; n++)
    begin
      r = next_random();
      write_reg(8'd8, r[7:0]);
      compare_all("route");
    end

    $display("value errors %0d, assertion failures %0d", errors, dut.chk.assert_fails);
    if (errors == 0 && dut.chk.assert_fails == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

  initial
  begin
    #(TIMEOUT_NS);
    $display("watchdog expired before the tests finished");
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+include
src/smu_ctl_pkg.sv
src/spi_frame_rx.sv
src/control_reg_bank.sv
src/spi_route.sv
src/smu_ctl_top.sv
bench/smu_ctl_chk.sv
bench/smu_ctl_tb.sv

//--- Makefile
# verilator build and run of the smu control fpga testbench

VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = smu_ctl_tb
FLIST     = flist.f
OBJ_DIR   = obj_dir
RUN_FLAGS = +verilator+error+limit+1000
LOG       = sim.log
FAIL_MSG  = Simulation failed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
